//--- rtl/fma_pkg.sv
package fma_pkg;

   // FP16 word layout
   localparam int FP_W     = 16;
   localparam int EXP_W    = 5;
   localparam int MAN_W    = 10;
   localparam int SIG_W    = MAN_W + 1;
   localparam int PROD_W   = 2 * SIG_W;
   localparam int EXP_BIAS = 15;

   // The working sum is the product frame with five bits of headroom above
   // and one sticky bit below
   localparam int SUM_W  = PROD_W + 6;
   localparam int XEXP_W = 8;

   // Rounding modes in SoftFloat order
   localparam logic [1:0] RM_NEAREST_EVEN = 2'd0;
   localparam logic [1:0] RM_TO_ZERO      = 2'd1;
   localparam logic [1:0] RM_MINUS_INF    = 2'd2;
   localparam logic [1:0] RM_PLUS_INF     = 2'd3;

   // Exception vector bit positions
   localparam int EXC_W         = 4;
   localparam int EXC_INEXACT   = 0;
   localparam int EXC_UNDERFLOW = 1;
   localparam int EXC_OVERFLOW  = 2;
   localparam int EXC_INVALID   = 3;

   localparam logic [FP_W-1:0] QNAN_DEFAULT = 16'hfe00;

   // Magnitude patterns only, the sign bit is concatenated in front where used
   localparam logic [FP_W-2:0] POS_INF    = 15'h7c00;
   localparam logic [FP_W-2:0] MAX_FINITE = 15'h7bff;

   // One FP16 word seen either as a number or as a NaN with quiet bit and payload
   typedef union packed {
      struct packed {
         logic             sign;
         logic [EXP_W-1:0] exp;
         logic [MAN_W-1:0] man;
      } fields;
      struct packed {
         logic             sign;
         logic [EXP_W-1:0] exp;
         logic             quiet;
         logic [MAN_W-2:0] payload;
      } nan;
   } fp16_word_u;

endpackage

//--- rtl/fma_special_case.sv
module fma_special_case import fma_pkg::*; (
   input  logic            clock,
   input  logic            resetN,
   input  logic            go,
   input  logic [FP_W-1:0] multiplier,
   input  logic [FP_W-1:0] multiplicand,
   input  logic [FP_W-1:0] addend,
   input  logic [1:0]      rounding_mode,
   output logic            use_special,
   output logic [FP_W-1:0] special_result,
   output logic            special_invalid
);

   fp16_word_u mr_q, md_q, ad_q;
   fp16_word_u res;
   fp16_word_u result_w;
   logic [1:0] rmode_q;
   logic       go_q;
   logic       mr_zero, mr_inf, mr_qnan, mr_snan;
   logic       md_zero, md_inf, md_qnan, md_snan;
   logic       ad_zero, ad_inf, ad_qnan, ad_snan;
   logic       prod_sign, prod_inf, zero_times_inf;
   logic       hit, invalid;

   // Subnormals count as zero here
   function automatic logic is_zero(fp16_word_u w);
      return w.fields.exp == '0;
   endfunction

   function automatic logic is_inf(fp16_word_u w);
      return (&w.fields.exp) && (w.fields.man == '0);
   endfunction

   function automatic logic is_qnan(fp16_word_u w);
      return (&w.nan.exp) && w.nan.quiet;
   endfunction

   function automatic logic is_snan(fp16_word_u w);
      return (&w.nan.exp) && !w.nan.quiet && (w.nan.payload != '0);
   endfunction

   always_ff @(posedge clock) begin
      if (go) begin
         mr_q    <= multiplier;
         md_q    <= multiplicand;
         ad_q    <= addend;
         rmode_q <= rounding_mode;
         mr_zero <= is_zero(multiplier);
         mr_inf  <= is_inf(multiplier);
         mr_qnan <= is_qnan(multiplier);
         mr_snan <= is_snan(multiplier);
         md_zero <= is_zero(multiplicand);
         md_inf  <= is_inf(multiplicand);
         md_qnan <= is_qnan(multiplicand);
         md_snan <= is_snan(multiplicand);
         ad_zero <= is_zero(addend);
         ad_inf  <= is_inf(addend);
         ad_qnan <= is_qnan(addend);
         ad_snan <= is_snan(addend);
      end
   end

   // Priority follows the reference order: signalling NaNs, zero times infinity,
   // quiet NaNs, infinite product, infinite addend, then a zero product
   always_comb begin
      prod_sign = mr_q.fields.sign ^ md_q.fields.sign;
      prod_inf = (mr_inf | md_inf) & !(mr_qnan | mr_snan | md_qnan | md_snan);
      zero_times_inf = (mr_zero & md_inf) | (mr_inf & md_zero);
      hit = 1'b1;
      invalid = 1'b0;
      res = ad_q;
      if (ad_snan) begin
         res.nan.quiet = 1'b1;
         invalid = 1'b1;
      end else if (mr_snan) begin
         res = mr_q;
         res.nan.quiet = 1'b1;
         invalid = 1'b1;
      end else if (md_snan) begin
         res = md_q;
         res.nan.quiet = 1'b1;
         invalid = 1'b1;
      end else if (zero_times_inf) begin
         res = QNAN_DEFAULT;
         invalid = 1'b1;
      end else if (mr_qnan) begin
         res = mr_q;
      end else if (md_qnan) begin
         res = md_q;
      end else if (ad_qnan) begin
         res = ad_q;
      end else if (prod_inf && ad_inf && (prod_sign != ad_q.fields.sign)) begin
         // Opposite infinities cancel
         res = QNAN_DEFAULT;
         invalid = 1'b1;
      end else if (prod_inf) begin
         res = {prod_sign, POS_INF};
      end else if (ad_inf) begin
         res = ad_q;
      end else if ((mr_zero | md_zero) & ad_zero) begin
         if (rmode_q == RM_MINUS_INF)
            res = {prod_sign | ad_q.fields.sign, {(FP_W-1){1'b0}}};
         else
            res = {prod_sign & ad_q.fields.sign, {(FP_W-1){1'b0}}};
      end else if (mr_zero | md_zero) begin
         res = ad_q;
      end else begin
         hit = 1'b0;
      end
   end

   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN) begin
         go_q <= 1'b0;
         use_special <= 1'b0;
         special_invalid <= 1'b0;
      end else begin
         go_q <= go;
         if (go_q) begin
            use_special <= hit;
            special_invalid <= invalid;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (go_q)
         special_result <= res;
   end

   assign result_w = special_result;

   a_invalid_gives_nan: assert property (@(posedge clock) disable iff (!resetN)
      special_invalid |-> ((&result_w.fields.exp) && (result_w.fields.man != '0)));

endmodule

//--- rtl/fma_product_align.sv
module fma_product_align import fma_pkg::*; (
   input  logic                     clock,
   input  logic                     resetN,
   input  logic                     go,
   input  logic [FP_W-1:0]          multiplier,
   input  logic [FP_W-1:0]          multiplicand,
   input  logic [FP_W-1:0]          addend,
   input  logic [1:0]               rounding_mode,
   output logic                     stage_a_valid,
   output logic [PROD_W-1:0]        prod_sig,
   output logic                     prod_sign,
   output logic [SUM_W-1:0]         addend_sig_aligned,
   output logic                     addend_sign,
   output logic signed [XEXP_W-1:0] sum_exp,
   output logic                     sticky_in,
   output logic [1:0]               rmode_a
);

   fp16_word_u               mr_w, md_w, ad_w;
   logic [SIG_W-1:0]         mr_sig, md_sig, ad_sig;
   logic signed [XEXP_W-1:0] mr_exp, md_exp, ad_exp;
   logic signed [XEXP_W-1:0] prod_exp, exp_diff, sum_exp_d;
   logic [XEXP_W-1:0]        prod_shift, ad_shift;
   logic [PROD_W-1:0]        prod_full;
   logic [2*PROD_W-1:0]      prod_ext, ad_ext;
   logic                     prod_larger;

   function automatic logic [SIG_W-1:0] unpack_sig(fp16_word_u w);
      return (w.fields.exp == '0) ? '0 : {1'b1, w.fields.man};
   endfunction

   function automatic logic signed [XEXP_W-1:0] unpack_exp(fp16_word_u w);
      return XEXP_W'(w.fields.exp) - XEXP_W'(EXP_BIAS);
   endfunction

   assign mr_w = multiplier;
   assign md_w = multiplicand;
   assign ad_w = addend;

   // Both terms sit in a 22 bit frame with 20 fraction bits. The addend
   // significand starts one bit below the top of that frame.
   always_comb begin
      mr_sig = unpack_sig(mr_w);
      md_sig = unpack_sig(md_w);
      ad_sig = unpack_sig(ad_w);
      mr_exp = unpack_exp(mr_w);
      md_exp = unpack_exp(md_w);
      ad_exp = unpack_exp(ad_w);
      prod_full = mr_sig * md_sig;
      prod_exp = mr_exp + md_exp;
      exp_diff = prod_exp - ad_exp;
      // A zero addend must never pull the product out of its frame
      prod_larger = (ad_sig == '0) || !exp_diff[XEXP_W-1];
      prod_shift = '0;
      ad_shift = '0;
      if (prod_larger) begin
         sum_exp_d = prod_exp;
         ad_shift = (exp_diff > XEXP_W'(PROD_W)) ? XEXP_W'(PROD_W) : exp_diff;
      end else begin
         sum_exp_d = ad_exp;
         prod_shift = (-exp_diff > XEXP_W'(PROD_W)) ? XEXP_W'(PROD_W) : -exp_diff;
      end
      prod_ext = {prod_full, {PROD_W{1'b0}}} >> prod_shift;
      ad_ext = {1'b0, ad_sig, {(PROD_W-SIG_W-1){1'b0}}, {PROD_W{1'b0}}} >> ad_shift;
   end

   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN)
         stage_a_valid <= 1'b0;
      else
         stage_a_valid <= go;
   end

   // The addend keeps its own sticky bit in the low bit of the working layout
   always_ff @(posedge clock) begin
      if (go) begin
         prod_sig <= prod_ext[2*PROD_W-1 -: PROD_W];
         sticky_in <= |prod_ext[PROD_W-1:0];
         prod_sign <= mr_w.fields.sign ^ md_w.fields.sign;
         addend_sig_aligned <= {{(SUM_W-PROD_W-1){1'b0}},
                                ad_ext[2*PROD_W-1 -: PROD_W], |ad_ext[PROD_W-1:0]};
         addend_sign <= ad_w.fields.sign;
         sum_exp <= sum_exp_d;
         rmode_a <= rounding_mode;
      end
   end

endmodule

//--- rtl/fma_normalize_round.sv
module fma_normalize_round import fma_pkg::*; (
   input  logic                     clock,
   input  logic                     resetN,
   input  logic                     stage_a_valid,
   input  logic [PROD_W-1:0]        prod_sig,
   input  logic                     prod_sign,
   input  logic [SUM_W-1:0]         addend_sig_aligned,
   input  logic                     addend_sign,
   input  logic signed [XEXP_W-1:0] sum_exp,
   input  logic                     sticky_in,
   input  logic [1:0]               rmode_a,
   output logic                     stage_b_valid,
   output logic [FP_W-1:0]          arith_result,
   output logic [EXC_W-1:0]         arith_exc
);

   logic [SUM_W-1:0]         prod_work, diff, mag, norm;
   logic signed [XEXP_W-1:0] lead_pos, norm_exp, biased_exp;
   logic [MAN_W:0]           rounded;
   logic                     res_sign;
   logic                     guard_bit, round_bit, sticky_bit, lost;
   logic                     inc, ovf_to_inf;
   fp16_word_u               res_w;
   logic [EXC_W-1:0]         exc;

   always_comb begin
      prod_work = {{(SUM_W-PROD_W-1){1'b0}}, prod_sig, sticky_in};
      diff = prod_work - addend_sig_aligned;
      if (prod_sign == addend_sign) begin
         mag = prod_work + addend_sig_aligned;
         res_sign = prod_sign;
      end else if (diff[SUM_W-1]) begin
         // The addend had the larger magnitude
         mag = -diff;
         res_sign = addend_sign;
      end else begin
         mag = diff;
         res_sign = prod_sign;
      end

      lead_pos = '0;
      for (int i = 0; i < SUM_W; i++) begin
         if (mag[i])
            lead_pos = XEXP_W'(i);
      end
      norm = mag << (SUM_W - 1 - lead_pos);
      // Frame bit 20 is the units position, which is bit 21 of the working sum
      norm_exp = sum_exp + lead_pos - XEXP_W'(PROD_W - 1);

      guard_bit = norm[SUM_W-MAN_W-2];
      round_bit = norm[SUM_W-MAN_W-3];
      sticky_bit = |norm[SUM_W-MAN_W-4:0];
      lost = guard_bit | round_bit | sticky_bit;

      case (rmode_a)
         RM_NEAREST_EVEN: begin
            inc = guard_bit & (norm[SUM_W-MAN_W-1] | round_bit | sticky_bit);
            ovf_to_inf = 1'b1;
         end
         RM_TO_ZERO: begin
            inc = 1'b0;
            ovf_to_inf = 1'b0;
         end
         RM_MINUS_INF: begin
            inc = res_sign & lost;
            ovf_to_inf = res_sign;
         end
         RM_PLUS_INF: begin
            inc = !res_sign & lost;
            ovf_to_inf = !res_sign;
         end
      endcase

      // A carry out of the mantissa leaves it all zero and bumps the exponent
      rounded = {1'b0, norm[SUM_W-2 -: MAN_W]} + {{MAN_W{1'b0}}, inc};
      biased_exp = norm_exp + XEXP_W'(EXP_BIAS) + {{(XEXP_W-1){1'b0}}, rounded[MAN_W]};

      res_w.fields.sign = res_sign;
      res_w.fields.exp = biased_exp[EXP_W-1:0];
      res_w.fields.man = rounded[MAN_W-1:0];
      exc = '0;
      exc[EXC_INEXACT] = lost;
      if (mag == '0) begin
         // Exact cancellation is negative only when rounding toward minus infinity
         res_w = '0;
         res_w.fields.sign = (rmode_a == RM_MINUS_INF);
      end else if (biased_exp >= XEXP_W'(2**EXP_W - 1)) begin
         res_w = {res_sign, ovf_to_inf ? POS_INF : MAX_FINITE};
         exc[EXC_OVERFLOW] = 1'b1;
         exc[EXC_INEXACT] = 1'b1;
      end else if (biased_exp[XEXP_W-1] || (biased_exp == '0)) begin
         res_w = {res_sign, {(FP_W-1){1'b0}}};
         exc[EXC_UNDERFLOW] = 1'b1;
         exc[EXC_INEXACT] = 1'b1;
      end
   end

   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN)
         stage_b_valid <= 1'b0;
      else
         stage_b_valid <= stage_a_valid;
   end

   always_ff @(posedge clock) begin
      if (stage_a_valid) begin
         arith_result <= res_w;
         arith_exc <= exc;
      end
   end

   a_rmode_known: assert property (@(posedge clock) disable iff (!resetN)
      stage_a_valid |-> !$isunknown(rmode_a));

endmodule

//--- rtl/fma_result_select.sv
module fma_result_select import fma_pkg::*; (
   input  logic             clock,
   input  logic             resetN,
   input  logic             stage_b_valid,
   input  logic             use_special,
   input  logic [FP_W-1:0]  special_result,
   input  logic             special_invalid,
   input  logic [FP_W-1:0]  arith_result,
   input  logic [EXC_W-1:0] arith_exc,
   output logic [FP_W-1:0]  result,
   output logic [EXC_W-1:0] exceptions,
   output logic             valid
);

   logic [EXC_W-1:0] special_exc;

   // Special results can only raise invalid
   always_comb begin
      special_exc = '0;
      special_exc[EXC_INVALID] = special_invalid;
   end

   always_ff @(posedge clock or negedge resetN) begin
      if (!resetN) begin
         valid <= 1'b0;
         result <= '0;
         exceptions <= '0;
      end else begin
         valid <= stage_b_valid;
         if (stage_b_valid) begin
            result <= use_special ? special_result : arith_result;
            exceptions <= use_special ? special_exc : arith_exc;
         end
      end
   end

   // Both paths must have loaded their registers by the time valid rises
   a_valid_result_known: assert property (@(posedge clock) disable iff (!resetN)
      valid |-> !$isunknown({result, exceptions}));

   a_no_invalid_overflow: assert property (@(posedge clock) disable iff (!resetN)
      !(exceptions[EXC_INVALID] && exceptions[EXC_OVERFLOW]));

endmodule

//--- rtl/fma_top.sv
module fma_top import fma_pkg::*; (
   input  logic             clock,
   input  logic             resetN,
   input  logic             go,
   input  logic [FP_W-1:0]  multiplier,
   input  logic [FP_W-1:0]  multiplicand,
   input  logic [FP_W-1:0]  addend,
   input  logic [1:0]       rounding_mode,
   output logic [FP_W-1:0]  result,
   output logic [EXC_W-1:0] exceptions,
   output logic             valid
);

   // Special operand path
   logic                     use_special;
   logic [FP_W-1:0]          special_result;
   logic                     special_invalid;

   // Arithmetic stage A to stage B
   logic                     stage_a_valid;
   logic [PROD_W-1:0]        prod_sig;
   logic                     prod_sign;
   logic [SUM_W-1:0]         addend_sig_aligned;
   logic                     addend_sign;
   logic signed [XEXP_W-1:0] sum_exp;
   logic                     sticky_in;
   logic [1:0]               rmode_a;

   // Arithmetic stage B to the selector
   logic                     stage_b_valid;
   logic [FP_W-1:0]          arith_result;
   logic [EXC_W-1:0]         arith_exc;

   fma_special_case special_i (.*);

   fma_product_align align_i (.*);

   fma_normalize_round round_i (.*);

   fma_result_select select_i (.*);

endmodule

//--- bench/fma_clock_gen.sv
module fma_clock_gen #(
   parameter int PERIOD       = 4,
   parameter int RESET_CYCLES = 16
) (
   output logic clock,
   output logic resetN
);

   initial begin
      clock = 1'b0;
      forever #(PERIOD / 2) clock = ~clock;
   end

   // Reset is released on a falling edge, half a period away from any sampling edge
   initial begin
      resetN = 1'b0;
      #(PERIOD * RESET_CYCLES) resetN = 1'b1;
   end

endmodule

//--- bench/fma_tb.sv
module fma_tb import fma_pkg::*; ();

   localparam int PERIOD       = 4;
   localparam int RESET_CYCLES = 16;
   localparam int LATENCY      = 2;
   localparam int COLS         = 7;
   localparam int MAX_VEC      = 64;
   localparam int NUM_GROUPS   = 5;

   logic             clock;
   logic             resetN;
   logic             go;
   logic [FP_W-1:0]  multiplier;
   logic [FP_W-1:0]  multiplicand;
   logic [FP_W-1:0]  addend;
   logic [1:0]       rounding_mode;
   logic [FP_W-1:0]  result;
   logic [EXC_W-1:0] exceptions;
   logic             valid;

   // Each vector takes COLS words: group, three operands, mode, result, exceptions
   logic [15:0] vec_mem [0:COLS*MAX_VEC-1];
   int          num_vec = 0;
   int          checked = 0;
   int          error_count = 0;
   int          cycle_count = 0;
   int          seed = 54;
   int          group_size [1:NUM_GROUPS];
   int          group_done [1:NUM_GROUPS];
   int          group_errors [1:NUM_GROUPS];

   // Vector numbers and issuing edges of the operations still in flight
   int          pending_vec [$];
   int          issue_edge [$];

   fma_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_i (
      .clock (clock),
      .resetN(resetN)
   );

   fma_top dut_i (
      .clock        (clock),
      .resetN       (resetN),
      .go           (go),
      .multiplier   (multiplier),
      .multiplicand (multiplicand),
      .addend       (addend),
      .rounding_mode(rounding_mode),
      .result       (result),
      .exceptions   (exceptions),
      .valid        (valid)
   );

   function automatic string group_label(input int grp);
      case (grp)
         1: return "normal FMA";
         2: return "rounding modes";
         3: return "overflow and underflow";
         4: return "special operands";
         default: return "back-to-back issue";
      endcase
   endfunction

   task automatic load_vectors();
      int grp;
      for (int i = 0; i < COLS * MAX_VEC; i++)
         vec_mem[i] = '0;
      for (int g = 1; g <= NUM_GROUPS; g++) begin
         group_size[g] = 0;
         group_done[g] = 0;
         group_errors[g] = 0;
      end
      $readmemh("bench/fma_stimulus.txt", vec_mem);
      // A zero group number marks the end of the vectors
      while (num_vec < MAX_VEC && vec_mem[num_vec * COLS] != '0) begin
         grp = int'(vec_mem[num_vec * COLS]);
         group_size[grp]++;
         num_vec++;
      end
   endtask

   task automatic check_value(input string what, input int vec, input int grp,
                              input logic [31:0] got, input logic [31:0] expected);
      if (got !== expected) begin
         error_count++;
         group_errors[grp]++;
         $display("error at time %0t: vector %0d %s is %0h, expected %0h",
                  $time, vec, what, got, expected);
      end
   endtask

   task automatic compare_result();
      int vec;
      int grp;
      int base;
      if (pending_vec.size() == 0) begin
         error_count++;
         $display("Unexpected result %0h at time %0t with no operation in flight",
                  result, $time);
      end else begin
         vec = pending_vec.pop_front();
         base = vec * COLS;
         grp = int'(vec_mem[base]);
         check_value("result", vec, grp, 32'(result), 32'(vec_mem[base + 5]));
         check_value("exceptions", vec, grp, 32'(exceptions), 32'(vec_mem[base + 6]));
         check_value("latency in cycles", vec, grp,
                     32'(cycle_count - issue_edge.pop_front()), 32'(LATENCY));
         checked++;
         group_done[grp]++;
         if (group_done[grp] == group_size[grp])
            $display("Group %0d (%s) finished: %0d vectors, %0d errors",
                     grp, group_label(grp), group_size[grp], group_errors[grp]);
      end
   endtask

   always @(posedge clock)
      cycle_count <= cycle_count + 1;

   // Outputs are sampled on the falling edge, half a period after they change
   always @(negedge clock) begin
      if (valid)
         compare_result();
   end

   initial begin
      int gap;
      int base;
      go = 1'b0;
      multiplier = '0;
      multiplicand = '0;
      addend = '0;
      rounding_mode = RM_NEAREST_EVEN;
      load_vectors();
      if (num_vec == 0) begin
         $display("The stimulus file held no test vectors");
         error_count++;
      end
      wait (resetN === 1'b1);
      @(negedge clock);
      for (int v = 0; v < num_vec; v++) begin
         base = v * COLS;
         go = 1'b1;
         multiplier = vec_mem[base + 1];
         multiplicand = vec_mem[base + 2];
         addend = vec_mem[base + 3];
         rounding_mode = vec_mem[base + 4][1:0];
         pending_vec.push_back(v);
         // The next rising edge samples go
         issue_edge.push_back(cycle_count + 1);
         @(negedge clock);
         go = 1'b0;
         gap = {$random(seed)} % 3;
         repeat (gap) @(negedge clock);
      end
      wait (checked == num_vec);
      // A few idle cycles catch any extra valid pulse
      repeat (4) @(negedge clock);
      $display("Checked %0d of %0d vectors, %0d errors", checked, num_vec, error_count);
      if (error_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Each vector needs at most three cycles including the longest idle gap
   initial begin
      wait (num_vec > 0);
      #((num_vec * 3 + RESET_CYCLES + 20) * PERIOD);
      $display("Timeout: results for %0d of %0d vectors never arrived",
               num_vec - checked, num_vec);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- bench/fma_stimulus.txt
// group multiplier multiplicand addend rounding_mode expected_result expected_exceptions
// Exception bits are 8 invalid, 4 overflow, 2 underflow and 1 inexact
1 4000 4200 3c00 0 4700 0
1 3e00 3e00 3400 0 4100 0
1 3c00 3c00 0c00 0 3c00 1
1 3c01 3c01 bc00 0 1800 1
2 3c00 3c00 1200 0 3c01 1
2 3c00 3c00 1200 1 3c00 1
2 3c00 3c00 1200 2 3c00 1
2 3c00 3c00 1200 3 3c01 1
2 bc00 3c00 9200 2 bc01 1
2 bc00 3c00 9200 3 bc00 1
2 3c00 3c00 bc00 0 0000 0
2 3c00 3c00 bc00 2 8000 0
3 7800 4000 0000 0 7c00 5
3 7800 4000 0000 1 7bff 5
3 f800 4000 0000 3 fbff 5
3 0400 3800 0000 0 0000 3
3 0200 4000 3c00 0 3c00 0
3 3c00 3c00 0001 0 3c00 0
4 0000 7c00 3c00 0 fe00 8
4 7c00 4000 fc00 0 fe00 8
4 3c00 3c00 7d00 0 7f00 8
4 7e05 4000 3c00 0 7e05 0
4 8000 4000 4500 0 4500 0
4 8000 3c00 0000 2 8000 0
5 4200 4200 4000 0 4980 0
5 4500 4500 c200 0 4d80 0
5 4900 4900 3c00 0 5650 0
5 c400 4200 4900 0 c000 0

//--- flist.f
rtl/fma_pkg.sv
rtl/fma_special_case.sv
rtl/fma_product_align.sv
rtl/fma_normalize_round.sv
rtl/fma_result_select.sv
rtl/fma_top.sv
bench/fma_clock_gen.sv
bench/fma_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fma_tb -f flist.f \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vfma_tb > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "FAIL: no pass message in sim.log"; exit 1; }
echo "PASS"
